// ==== include/game_cfg.svh ====
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

//////////////////////////////
// vga stream widths
//////////////////////////////

// counters and mouse positions share one width.
`define GAME_POS_W 12

// 4 bits per colour channel, red in the top nibble.
`define GAME_RGB_W 12

//////////////////////////////
// sprites
//////////////////////////////

// the drawn cursor fits in a square of this side.
`define CURSOR_SIZE 16
`define CURSOR_RGB 12'hFFF

// glove sprite side and its rom address width (5 bits of row, 5 of column).
`define GLOVES_SIZE 32
`define GLOVES_ADDR_W 10

`endif

// ==== source/game_pkg.sv ====
`include "game_cfg.svh"

package game_pkg;

    //////////////////////////////
    // game state
    //////////////////////////////

    // the game logic drives this, the mouse block only reads it.
    typedef enum logic [1:0] {
        MENU,
        SHOOTER,
        KEEPER
    } g_state;

    //////////////////////////////
    // pixel timing
    //////////////////////////////

    // hcount, vcount and the mouse coordinates.
    typedef logic [`GAME_POS_W-1:0] vga_pos_t;

    // one pixel colour as {red, green, blue}.
    typedef logic [`GAME_RGB_W-1:0] rgb_t;

endpackage

// ==== source/cursor_draw.sv ====
`include "game_cfg.svh"

module cursor_draw
    import game_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  vga_pos_t xpos,
    input  vga_pos_t ypos,
    input  vga_pos_t in_hcount,
    input  vga_pos_t in_vcount,
    input  logic     in_hsync,
    input  logic     in_vsync,
    input  logic     in_hblnk,
    input  logic     in_vblnk,
    input  rgb_t     in_rgb,
    output vga_pos_t out_hcount,
    output vga_pos_t out_vcount,
    output logic     out_hsync,
    output logic     out_vsync,
    output logic     out_hblnk,
    output logic     out_vblnk,
    output rgb_t     out_rgb
);

    vga_pos_t dx;
    vga_pos_t dy;
    logic     hit;

    vga_pos_t s1_hcount;
    vga_pos_t s1_vcount;
    logic     s1_hsync;
    logic     s1_vsync;
    logic     s1_hblnk;
    logic     s1_vblnk;
    rgb_t     s1_rgb;
    logic     s1_hit;

    // pixels left or above the mouse wrap to large values and fail the size test.
    always_comb begin
        dx  = in_hcount - xpos;
        dy  = in_vcount - ypos;
        hit = !(in_hblnk || in_vblnk)
              && (dx < vga_pos_t'(`CURSOR_SIZE)) && (dy < vga_pos_t'(`CURSOR_SIZE))
              && ((dx == '0) || (dy == '0) || (dx == dy));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_hcount  <= '0;
            s1_vcount  <= '0;
            s1_hsync   <= 1'b0;
            s1_vsync   <= 1'b0;
            s1_hblnk   <= 1'b0;
            s1_vblnk   <= 1'b0;
            s1_rgb     <= '0;
            s1_hit     <= 1'b0;
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            s1_hcount  <= in_hcount;
            s1_vcount  <= in_vcount;
            s1_hsync   <= in_hsync;
            s1_vsync   <= in_vsync;
            s1_hblnk   <= in_hblnk;
            s1_vblnk   <= in_vblnk;
            s1_rgb     <= in_rgb;
            s1_hit     <= hit;
            out_hcount <= s1_hcount;
            out_vcount <= s1_vcount;
            out_hsync  <= s1_hsync;
            out_vsync  <= s1_vsync;
            out_hblnk  <= s1_hblnk;
            out_vblnk  <= s1_vblnk;
            out_rgb    <= s1_hit ? `CURSOR_RGB : s1_rgb;
        end
    end

endmodule

// ==== source/gloves_draw.sv ====
`include "game_cfg.svh"

module gloves_draw
    import game_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  vga_pos_t                  xpos,
    input  vga_pos_t                  ypos,
    input  vga_pos_t                  in_hcount,
    input  vga_pos_t                  in_vcount,
    input  logic                      in_hsync,
    input  logic                      in_vsync,
    input  logic                      in_hblnk,
    input  logic                      in_vblnk,
    input  rgb_t                      in_rgb,
    output vga_pos_t                  out_hcount,
    output vga_pos_t                  out_vcount,
    output logic                      out_hsync,
    output logic                      out_vsync,
    output logic                      out_hblnk,
    output logic                      out_vblnk,
    output rgb_t                      out_rgb,
    output logic [`GLOVES_ADDR_W-1:0] rom_addr,
    input  rgb_t                      rom_rgb
);

    // the rom address splits evenly into row and column.
    localparam int IDX_W = `GLOVES_ADDR_W / 2;

    vga_pos_t dx;
    vga_pos_t dy;
    logic     hit;

    vga_pos_t s1_hcount;
    vga_pos_t s1_vcount;
    logic     s1_hsync;
    logic     s1_vsync;
    logic     s1_hblnk;
    logic     s1_vblnk;
    rgb_t     s1_rgb;
    logic     s1_hit;

    // the rom registers the address, so its colour lines up with stage 2.
    always_comb begin
        dx       = in_hcount - xpos;
        dy       = in_vcount - ypos;
        hit      = !(in_hblnk || in_vblnk)
                   && (dx < vga_pos_t'(`GLOVES_SIZE)) && (dy < vga_pos_t'(`GLOVES_SIZE));
        rom_addr = {dy[IDX_W-1:0], dx[IDX_W-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_hcount  <= '0;
            s1_vcount  <= '0;
            s1_hsync   <= 1'b0;
            s1_vsync   <= 1'b0;
            s1_hblnk   <= 1'b0;
            s1_vblnk   <= 1'b0;
            s1_rgb     <= '0;
            s1_hit     <= 1'b0;
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            s1_hcount  <= in_hcount;
            s1_vcount  <= in_vcount;
            s1_hsync   <= in_hsync;
            s1_vsync   <= in_vsync;
            s1_hblnk   <= in_hblnk;
            s1_vblnk   <= in_vblnk;
            s1_rgb     <= in_rgb;
            s1_hit     <= hit;
            out_hcount <= s1_hcount;
            out_vcount <= s1_vcount;
            out_hsync  <= s1_hsync;
            out_vsync  <= s1_vsync;
            out_hblnk  <= s1_hblnk;
            out_vblnk  <= s1_vblnk;
            out_rgb    <= s1_hit ? rom_rgb : s1_rgb;
        end
    end

endmodule

// ==== source/gloves_rom.sv ====
`include "game_cfg.svh"

module gloves_rom
    import game_pkg::*;
(
    input  logic                      clk,
    input  logic [`GLOVES_ADDR_W-1:0] addr,
    output rgb_t                      rom_rgb
);

    localparam int ADDR_W = `GLOVES_ADDR_W;
    localparam int DEPTH  = 1 << ADDR_W;
    localparam int IDX_W  = ADDR_W / 2;

    rgb_t mem [DEPTH];

    // row shades red, column shades green, blue is fixed so no entry is transparent.
    function automatic rgb_t glove_pixel(input logic [ADDR_W-1:0] a);
        logic [IDX_W-1:0] dy;
        logic [IDX_W-1:0] dx;
        dy = a[ADDR_W-1:IDX_W];
        dx = a[IDX_W-1:0];
        return {dy[4:1], dx[4:1], 4'hA};
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = glove_pixel(ADDR_W'(i));
        end
    end

    // one cycle read latency.
    always_ff @(posedge clk) begin
        rom_rgb <= mem[addr];
    end

endmodule

// ==== source/keeper_pos_tx.sv ====
module keeper_pos_tx
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  vga_pos_t   xpos,
    input  logic       tx_full,
    output logic [7:0] tx_data
);

    typedef enum logic [1:0] {
        WAIT,
        READY,
        SEND
    } tx_state_t;

    tx_state_t  state;
    tx_state_t  state_nxt;
    logic       half;
    logic       half_nxt;
    logic [7:0] tx_data_nxt;

    //////////////////////////////
    // state and byte registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= WAIT;
            half    <= 1'b0;
            tx_data <= 8'h00;
        end else begin
            state   <= state_nxt;
            half    <= half_nxt;
            tx_data <= tx_data_nxt;
        end
    end

    // the uart picks up a byte when tx_data changes, so tx_data only moves in SEND.
    always_comb begin
        state_nxt   = state;
        half_nxt    = half;
        tx_data_nxt = tx_data;
        case (state)
            WAIT: begin
                if (tx_full) begin
                    state_nxt = READY;
                end
            end
            READY: begin
                if (!tx_full) begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                state_nxt   = WAIT;
                tx_data_nxt = half ? {xpos[9:5], 3'b010} : {xpos[4:0], 3'b001};
                // without a full flag here the same half goes out again.
                if (tx_full) begin
                    half_nxt = !half;
                end
            end
            default: begin
                state_nxt = WAIT;
            end
        endcase
    end

endmodule

// ==== source/mouse_control.sv ====
`include "game_cfg.svh"

module mouse_control
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  vga_pos_t   xpos,
    input  vga_pos_t   ypos,
    input  g_state     game_state,
    input  logic       tx_full,
    input  vga_pos_t   in_hcount,
    input  vga_pos_t   in_vcount,
    input  logic       in_hsync,
    input  logic       in_vsync,
    input  logic       in_hblnk,
    input  logic       in_vblnk,
    input  rgb_t       in_rgb,
    output logic [7:0] tx_data,
    output vga_pos_t   out_hcount,
    output vga_pos_t   out_vcount,
    output logic       out_hsync,
    output logic       out_vsync,
    output logic       out_hblnk,
    output logic       out_vblnk,
    output rgb_t       out_rgb
);

    // stage 1 copies of the stream and the mouse inputs.
    vga_pos_t s1_hcount;
    vga_pos_t s1_vcount;
    logic     s1_hsync;
    logic     s1_vsync;
    logic     s1_hblnk;
    logic     s1_vblnk;
    rgb_t     s1_rgb;
    vga_pos_t s1_xpos;
    vga_pos_t s1_ypos;
    g_state   s1_state;
    g_state   state_dly [2];

    vga_pos_t cur_hcount;
    vga_pos_t cur_vcount;
    logic     cur_hsync;
    logic     cur_vsync;
    logic     cur_hblnk;
    logic     cur_vblnk;
    rgb_t     cur_rgb;

    vga_pos_t glv_hcount;
    vga_pos_t glv_vcount;
    logic     glv_hsync;
    logic     glv_vsync;
    logic     glv_hblnk;
    logic     glv_vblnk;
    rgb_t     glv_rgb;

    logic [`GLOVES_ADDR_W-1:0] glv_addr;
    rgb_t                      glv_rom_rgb;

    vga_pos_t sel_hcount;
    vga_pos_t sel_vcount;
    logic     sel_hsync;
    logic     sel_vsync;
    logic     sel_hblnk;
    logic     sel_vblnk;
    rgb_t     sel_rgb;

    //////////////////////////////
    // input side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_hcount    <= '0;
            s1_vcount    <= '0;
            s1_hsync     <= 1'b0;
            s1_vsync     <= 1'b0;
            s1_hblnk     <= 1'b0;
            s1_vblnk     <= 1'b0;
            s1_rgb       <= '0;
            s1_xpos      <= '0;
            s1_ypos      <= '0;
            s1_state     <= MENU;
            state_dly[0] <= MENU;
            state_dly[1] <= MENU;
        end else begin
            s1_hcount    <= in_hcount;
            s1_vcount    <= in_vcount;
            s1_hsync     <= in_hsync;
            s1_vsync     <= in_vsync;
            s1_hblnk     <= in_hblnk;
            s1_vblnk     <= in_vblnk;
            s1_rgb       <= in_rgb;
            s1_xpos      <= xpos;
            s1_ypos      <= ypos;
            s1_state     <= game_state;
            // the drawers take two cycles, so the state follows them by two.
            state_dly[0] <= s1_state;
            state_dly[1] <= state_dly[0];
        end
    end

    cursor_draw u_cursor_draw (
        .clk        (clk),
        .rst        (rst),
        .xpos       (s1_xpos),
        .ypos       (s1_ypos),
        .in_hcount  (s1_hcount),
        .in_vcount  (s1_vcount),
        .in_hsync   (s1_hsync),
        .in_vsync   (s1_vsync),
        .in_hblnk   (s1_hblnk),
        .in_vblnk   (s1_vblnk),
        .in_rgb     (s1_rgb),
        .out_hcount (cur_hcount),
        .out_vcount (cur_vcount),
        .out_hsync  (cur_hsync),
        .out_vsync  (cur_vsync),
        .out_hblnk  (cur_hblnk),
        .out_vblnk  (cur_vblnk),
        .out_rgb    (cur_rgb)
    );

    gloves_draw u_gloves_draw (
        .clk        (clk),
        .rst        (rst),
        .xpos       (s1_xpos),
        .ypos       (s1_ypos),
        .in_hcount  (s1_hcount),
        .in_vcount  (s1_vcount),
        .in_hsync   (s1_hsync),
        .in_vsync   (s1_vsync),
        .in_hblnk   (s1_hblnk),
        .in_vblnk   (s1_vblnk),
        .in_rgb     (s1_rgb),
        .out_hcount (glv_hcount),
        .out_vcount (glv_vcount),
        .out_hsync  (glv_hsync),
        .out_vsync  (glv_vsync),
        .out_hblnk  (glv_hblnk),
        .out_vblnk  (glv_vblnk),
        .out_rgb    (glv_rgb),
        .rom_addr   (glv_addr),
        .rom_rgb    (glv_rom_rgb)
    );

    gloves_rom u_gloves_rom (
        .clk     (clk),
        .addr    (glv_addr),
        .rom_rgb (glv_rom_rgb)
    );

    // the uart side reads the live mouse position.
    keeper_pos_tx u_keeper_pos_tx (
        .clk     (clk),
        .rst     (rst),
        .xpos    (xpos),
        .tx_full (tx_full),
        .tx_data (tx_data)
    );

    //////////////////////////////
    // output side
    //////////////////////////////

    always_comb begin
        if (state_dly[1] == KEEPER) begin
            sel_hcount = glv_hcount;
            sel_vcount = glv_vcount;
            sel_hsync  = glv_hsync;
            sel_vsync  = glv_vsync;
            sel_hblnk  = glv_hblnk;
            sel_vblnk  = glv_vblnk;
            sel_rgb    = glv_rgb;
        end else begin
            sel_hcount = cur_hcount;
            sel_vcount = cur_vcount;
            sel_hsync  = cur_hsync;
            sel_vsync  = cur_vsync;
            sel_hblnk  = cur_hblnk;
            sel_vblnk  = cur_vblnk;
            sel_rgb    = cur_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= sel_hcount;
            out_vcount <= sel_vcount;
            out_hsync  <= sel_hsync;
            out_vsync  <= sel_vsync;
            out_hblnk  <= sel_hblnk;
            out_vblnk  <= sel_vblnk;
            out_rgb    <= sel_rgb;
        end
    end

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 3;

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== test/mouse_control_tb.sv ====
`include "game_cfg.svh"

module mouse_control_tb
    import game_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_VIS        = 64;
    localparam int H_TOTAL      = 80;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 72;
    localparam int V_VIS        = 48;
    localparam int V_TOTAL      = 52;
    localparam int V_SYNC_START = 49;
    localparam int V_SYNC_END   = 51;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int NUM_FRAMES   = 6;
    localparam int CLK_NS       = 4;
    localparam int TIMEOUT_NS   = NUM_FRAMES * FRAME_CYCLES * CLK_NS * 2;
    localparam logic [31:0] RAND_SEED = 32'h4566dcc4;

    localparam int K_MENU    = 0;
    localparam int K_SHOOTER = 1;
    localparam int K_EDGE    = 2;
    localparam int K_KEEPER  = 3;
    localparam int K_SWITCH  = 4;
    localparam int K_UART    = 5;

    // one input pixel with the mouse inputs sampled alongside it.
    typedef struct packed {
        vga_pos_t hcount;
        vga_pos_t vcount;
        logic     hsync;
        logic     vsync;
        logic     hblnk;
        logic     vblnk;
        rgb_t     rgb;
        vga_pos_t xpos;
        vga_pos_t ypos;
        g_state   state;
    } pix_t;

    typedef enum logic [1:0] {
        U_IDLE,
        U_ARMED,
        U_SEND
    } uart_model_t;

    logic       clk;
    logic       rst;
    vga_pos_t   xpos;
    vga_pos_t   ypos;
    g_state     game_state;
    logic       tx_full;
    vga_pos_t   in_hcount;
    vga_pos_t   in_vcount;
    logic       in_hsync;
    logic       in_vsync;
    logic       in_hblnk;
    logic       in_vblnk;
    rgb_t       in_rgb;
    logic [7:0] tx_data;
    vga_pos_t   out_hcount;
    vga_pos_t   out_vcount;
    logic       out_hsync;
    logic       out_vsync;
    logic       out_hblnk;
    logic       out_vblnk;
    rgb_t       out_rgb;

    pix_t        pix_q [$];
    logic        was_reset    = 1'b0;
    uart_model_t uart_state   = U_IDLE;
    logic        uart_half    = 1'b0;
    logic [7:0]  uart_byte    = 8'h00;
    int          bytes_sent   = 0;
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    tb_clock u_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    mouse_control u_mouse_control (
        .clk        (clk),
        .rst        (rst),
        .xpos       (xpos),
        .ypos       (ypos),
        .game_state (game_state),
        .tx_full    (tx_full),
        .in_hcount  (in_hcount),
        .in_vcount  (in_vcount),
        .in_hsync   (in_hsync),
        .in_vsync   (in_vsync),
        .in_hblnk   (in_hblnk),
        .in_vblnk   (in_vblnk),
        .in_rgb     (in_rgb),
        .tx_data    (tx_data),
        .out_hcount (out_hcount),
        .out_vcount (out_vcount),
        .out_hsync  (out_hsync),
        .out_vsync  (out_vsync),
        .out_hblnk  (out_hblnk),
        .out_vblnk  (out_vblnk),
        .out_rgb    (out_rgb)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    // glove rows shade red, columns shade green, blue stays at A.
    function automatic rgb_t expected_rgb(input pix_t p);
        vga_pos_t dx;
        vga_pos_t dy;
        logic     visible;
        rgb_t     result;
        dx      = p.hcount - p.xpos;
        dy      = p.vcount - p.ypos;
        visible = !p.hblnk && !p.vblnk;
        result  = p.rgb;
        if (p.state == KEEPER) begin
            if (visible && dx < vga_pos_t'(`GLOVES_SIZE) && dy < vga_pos_t'(`GLOVES_SIZE)) begin
                result = {dy[4:1], dx[4:1], 4'hA};
            end
        end else if (visible && dx < vga_pos_t'(`CURSOR_SIZE)
                     && dy < vga_pos_t'(`CURSOR_SIZE)
                     && (dx == '0 || dy == '0 || dx == dy)) begin
            result = `CURSOR_RGB;
        end
        return result;
    endfunction

    function automatic pix_t sample_inputs();
        pix_t p;
        p.hcount = in_hcount;
        p.vcount = in_vcount;
        p.hsync  = in_hsync;
        p.vsync  = in_vsync;
        p.hblnk  = in_hblnk;
        p.vblnk  = in_vblnk;
        p.rgb    = in_rgb;
        p.xpos   = xpos;
        p.ypos   = ypos;
        p.state  = game_state;
        return p;
    endfunction

    // advances the uart model by the edge that follows this negedge.
    task automatic step_uart_model();
        if (rst) begin
            uart_state = U_IDLE;
            uart_half  = 1'b0;
            uart_byte  = 8'h00;
        end else begin
            case (uart_state)
                U_IDLE: if (tx_full) uart_state = U_ARMED;
                U_ARMED: if (!tx_full) uart_state = U_SEND;
                default: begin
                    uart_byte  = uart_half ? {xpos[9:5], 3'b010} : {xpos[4:0], 3'b001};
                    uart_half  = tx_full ? !uart_half : uart_half;
                    uart_state = U_IDLE;
                    bytes_sent++;
                end
            endcase
        end
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic expect_zero_outputs(input string when);
        assert ({out_hcount, out_vcount, out_hsync, out_vsync, out_hblnk, out_vblnk,
                 out_rgb, tx_data} == '0)
        else begin
            $display("FAILED %0t: outputs not zero %s", $time, when);
            error_count++;
        end
    endtask

    task automatic compare_pixel(input pix_t want);
        rgb_t want_rgb;
        want_rgb = expected_rgb(want);
        assert ({out_hcount, out_vcount, out_hsync, out_vsync, out_hblnk, out_vblnk}
                == {want.hcount, want.vcount, want.hsync, want.vsync, want.hblnk, want.vblnk})
        else begin
            $display("FAILED %0t: timing of pixel (%0d,%0d) came out as (%0d,%0d)",
                     $time, want.hcount, want.vcount, out_hcount, out_vcount);
            error_count++;
        end
        assert (out_rgb == want_rgb)
        else begin
            $display("FAILED %0t: rgb at (%0d,%0d) state %s mouse (%0d,%0d) is %h, want %h",
                     $time, want.hcount, want.vcount, want.state.name(), want.xpos,
                     want.ypos, out_rgb, want_rgb);
            error_count++;
        end
    endtask

    // outputs are read at the falling edge, away from the DUT's update.
    always @(negedge clk) begin
        pix_t want;
        if (rst) begin
            pix_q.delete();
            expect_zero_outputs("during reset");
            was_reset = 1'b1;
        end else begin
            if (was_reset) begin
                expect_zero_outputs("right after reset");
                was_reset = 1'b0;
            end
            if (pix_q.size() == 4) begin
                want = pix_q.pop_front();
                compare_pixel(want);
            end
            pix_q.push_back(sample_inputs());
        end
        assert (tx_data == uart_byte)
        else begin
            $display("FAILED %0t: tx_data is %h, want %h", $time, tx_data, uart_byte);
            error_count++;
        end
        step_uart_model();
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic pick_mouse(input int kind, input int line);
        case (kind)
            K_MENU, K_SHOOTER: begin
                if (line % 16 == 0) begin
                    xpos <= vga_pos_t'($urandom % 72);
                    ypos <= vga_pos_t'($urandom % 56);
                end
                game_state <= (kind == K_MENU) ? MENU : SHOOTER;
            end
            K_EDGE: begin
                if (line % 8 == 0) begin
                    xpos <= ($urandom % 2) ? vga_pos_t'($urandom % 4)
                                           : vga_pos_t'(60 + $urandom % 8);
                    ypos <= ($urandom % 2) ? vga_pos_t'($urandom % 4)
                                           : vga_pos_t'(44 + $urandom % 8);
                    game_state <= ($urandom % 2) ? MENU : SHOOTER;
                end
            end
            K_KEEPER: begin
                if (line % 12 == 0) begin
                    xpos <= vga_pos_t'($urandom % 72);
                    ypos <= vga_pos_t'($urandom % 56);
                end
                game_state <= KEEPER;
            end
            K_SWITCH: begin
                // the first pixels of each line fall inside both sprites, so a late state shows.
                if (line == 0) begin
                    xpos <= '0;
                    ypos <= vga_pos_t'($urandom % 24);
                end
                game_state <= g_state'(2'($urandom % 3));
            end
            default: begin
                // full range so both halves of the keeper position move.
                xpos       <= vga_pos_t'($urandom);
                ypos       <= vga_pos_t'($urandom % 56);
                game_state <= MENU;
            end
        endcase
    endtask

    task automatic drive_frame(input int kind);
        int   full_left;
        logic full_level;
        full_left  = 0;
        full_level = 1'b0;
        for (int v = 0; v < V_TOTAL; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                @(posedge clk);
                if (h == 0) begin
                    pick_mouse(kind, v);
                end
                if (kind == K_UART) begin
                    if (full_left == 0) begin
                        full_level = 1'($urandom % 2);
                        full_left  = 1 + int'($urandom % 6);
                    end
                    full_left--;
                    tx_full <= full_level;
                end else begin
                    tx_full <= 1'b0;
                end
                in_hcount <= vga_pos_t'(h);
                in_vcount <= vga_pos_t'(v);
                in_hblnk  <= (h >= H_VIS);
                in_hsync  <= (h >= H_SYNC_START) && (h < H_SYNC_END);
                in_vblnk  <= (v >= V_VIS);
                in_vsync  <= (v >= V_SYNC_START) && (v < V_SYNC_END);
                in_rgb    <= rgb_t'($urandom);
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, error_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic run_test(input string name, input int kind);
        int errs_before;
        int sent_before;
        errs_before = error_count;
        sent_before = bytes_sent;
        drive_frame(kind);
        if (kind == K_UART && bytes_sent == sent_before) begin
            $display("the uart test went a whole frame without sending a byte");
            error_count++;
        end
        report_test(name, errs_before);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        xpos       = '0;
        ypos       = '0;
        game_state = MENU;
        tx_full    = 1'b0;
        in_hcount  = '0;
        in_vcount  = '0;
        in_hsync   = 1'b0;
        in_vsync   = 1'b0;
        in_hblnk   = 1'b0;
        in_vblnk   = 1'b0;
        in_rgb     = '0;

        wait (!rst);
        @(negedge clk);
        @(posedge clk);
        report_test("reset", 0);

        run_test("cursor_menu", K_MENU);
        run_test("cursor_shooter", K_SHOOTER);
        run_test("cursor_edges", K_EDGE);
        run_test("gloves_keeper", K_KEEPER);
        run_test("state_switch", K_SWITCH);
        run_test("uart_bytes", K_UART);

        // let the last pixels leave the pipeline.
        repeat (8) @(posedge clk);
        $display("%0d tests run, %0d failed, %0d failed checks, %0d uart bytes",
                 tests_run, tests_failed, error_count, bytes_sent);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out after %0d ns before all tests finished", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
source/game_pkg.sv
source/cursor_draw.sv
source/gloves_draw.sv
source/gloves_rom.sv
source/keeper_pos_tx.sv
source/mouse_control.sv
test/tb_clock.sv
test/mouse_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the mouse block testbench with verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=mouse_control_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mouse_control_tb -f build.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict, the log search decides.
if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0
